// File: verilog/matrix_pkg.sv
package matrix_pkg;

    // ==================================================
    // matrix shapes and memory addressing
    // ==================================================

    typedef logic [7:0] dim_t;
    // products and offsets wrap at this width
    typedef logic [8:0] addr_t;
    // copies kept per shape, 0 to 2
    typedef logic [1:0] copy_cnt_t;
    typedef logic [2:0] slot_idx_t;

    typedef struct packed {
        dim_t m;
        dim_t n;
    } shape_t;

    // gaps in the encoding are unsupported operations
    typedef enum logic [2:0] {
        op_transpose = 3'd0,
        op_add       = 3'd1,
        op_matmul    = 3'd3
    } op_t;

    // ledger sizing
    localparam int NUM_SLOTS  = 8;
    localparam int MAX_COPIES = 2;

endpackage

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [4:0] {
        idle      = 5'd0,
        store     = 5'd1,
        sel_op    = 5'd2,
        get_dim   = 5'd3,
        get_id    = 5'd4,
        execute   = 5'd5,
        wait_done = 5'd6,
        decision  = 5'd7,
        error     = 5'd8
    } state_t;

    // board led patterns
    localparam logic [7:0] LED_IDLE     = 8'b0000_0001;
    localparam logic [7:0] LED_STORE    = 8'b0000_0010;
    localparam logic [7:0] LED_CALC     = 8'b0000_1000;
    localparam logic [7:0] LED_EXEC     = 8'b0100_0000;
    localparam logic [7:0] LED_DECISION = 8'b1000_0000;
    localparam logic [7:0] LED_ERROR    = 8'b1111_1111;

    // mode select on sw[1:0]
    localparam logic [1:0] MENU_STORE = 2'b00;
    localparam logic [1:0] MENU_CALC  = 2'b10;

    // start command to the calculator
    typedef struct packed {
        matrix_pkg::op_t   op;
        matrix_pkg::addr_t op1_addr;
        matrix_pkg::addr_t op2_addr;
        matrix_pkg::addr_t res_addr;
    } calc_cmd_t;

    typedef struct packed {
        logic               commit;
        matrix_pkg::shape_t key;
    } ledger_req_t;

endpackage

// File: verilog/shape_slot.sv
module shape_slot (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ctrl_pkg::ledger_req_t i_req,
    input  logic                  i_load,
    input  logic                  i_toggle,
    input  matrix_pkg::addr_t     i_start,
    output logic                  o_match,
    output matrix_pkg::addr_t     o_start,
    output logic                  o_bank,
    output matrix_pkg::copy_cnt_t o_count
);
    import matrix_pkg::*;

    shape_t    shape_q;
    addr_t     start_q;
    logic      bank_q;
    copy_cnt_t count_q;

    // stored shape and its base address
    always_ff @(posedge clk) begin
        if (i_load) begin
            shape_q <= i_req.key;
            start_q <= i_start;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_q  <= 1'b0;
            count_q <= '0;
        end else if (i_load) begin
            bank_q  <= 1'b1;
            count_q <= copy_cnt_t'(1);
        end else if (i_toggle) begin
            // next copy goes to the other half of the pair
            bank_q <= ~bank_q;
            if (count_q < MAX_COPIES) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // empty slot never matches
    assign o_match = (count_q != '0) && (shape_q == i_req.key);
    assign o_start = start_q;
    assign o_bank  = bank_q;
    assign o_count = count_q;

    a_load_xor_toggle: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_load && i_toggle));

endmodule

// File: verilog/ledger_writer.sv
module ledger_writer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  ctrl_pkg::ledger_req_t           i_req,
    input  logic                            i_hit,
    input  logic                            i_hit_bank,
    input  matrix_pkg::addr_t               i_hit_start,
    output logic [matrix_pkg::NUM_SLOTS-1:0] o_load,
    output logic                            o_toggle_en,
    output matrix_pkg::addr_t               o_free_ptr,
    output matrix_pkg::addr_t               o_target_addr,
    output logic [3:0]                      o_type_count
);
    import matrix_pkg::*;

    addr_t      key_size;
    addr_t      free_ptr_q;
    logic [3:0] count_q;
    slot_idx_t  load_idx;
    logic       full;
    logic       add_new;

    // words per matrix, wraps at address width
    assign key_size = addr_t'(i_req.key.m) * addr_t'(i_req.key.n);

    assign full     = (count_q == 4'(NUM_SLOTS));
    assign load_idx = slot_idx_t'(count_q);
    assign add_new  = i_req.commit && !i_hit && !full;

    // toggle is steered to the hit slot by the match vector
    assign o_toggle_en = i_req.commit && i_hit;

    always_comb begin
        o_load = '0;
        if (add_new) begin
            o_load[load_idx] = 1'b1;
        end
    end

    // ==================================================
    // target address of the next copy
    // ==================================================
    always_comb begin
        if (!i_hit) begin
            o_target_addr = free_ptr_q;
        end else if (i_hit_bank) begin
            o_target_addr = i_hit_start + key_size;
        end else begin
            o_target_addr = i_hit_start;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_ptr_q <= '0;
            count_q    <= '0;
        end else if (add_new) begin
            // room for two copies of the new shape
            free_ptr_q <= free_ptr_q + (key_size << 1);
            count_q    <= count_q + 4'd1;
        end
    end

    assign o_free_ptr   = free_ptr_q;
    assign o_type_count = count_q;

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= 4'(NUM_SLOTS));

endmodule

// File: verilog/ledger_match.sv
module ledger_match (
    input  logic                                              clk,
    input  logic [matrix_pkg::NUM_SLOTS-1:0]                  i_match,
    input  matrix_pkg::addr_t [matrix_pkg::NUM_SLOTS-1:0]     i_start,
    input  logic [matrix_pkg::NUM_SLOTS-1:0]                  i_bank,
    input  matrix_pkg::copy_cnt_t [matrix_pkg::NUM_SLOTS-1:0] i_count,
    output logic                                              o_hit,
    output matrix_pkg::addr_t                                 o_hit_start,
    output logic                                              o_hit_bank,
    output matrix_pkg::copy_cnt_t                             o_hit_count
);
    import matrix_pkg::*;

    // shapes are unique in the ledger, so an OR picks the hit slot
    always_comb begin
        o_hit       = |i_match;
        o_hit_start = '0;
        o_hit_bank  = 1'b0;
        o_hit_count = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (i_match[i]) begin
                o_hit_start = o_hit_start | i_start[i];
                o_hit_bank  = o_hit_bank | i_bank[i];
                o_hit_count = o_hit_count | i_count[i];
            end
        end
    end

    a_unique_match: assert property (@(posedge clk) $onehot0(i_match));

endmodule

// File: verilog/matrix_ctrl_fsm.sv
module matrix_ctrl_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            i_sw,
    input  logic [2:0]            i_btn,
    input  matrix_pkg::shape_t    i_dims,
    input  logic                  i_dims_valid,
    input  logic [1:0]            i_id,
    input  logic                  i_id_valid,
    input  logic                  i_rx_done,
    input  logic                  i_timeout,
    input  logic                  i_calc_done,
    input  logic                  i_hit,
    input  matrix_pkg::addr_t     i_hit_start,
    input  matrix_pkg::copy_cnt_t i_hit_count,
    input  matrix_pkg::addr_t     i_target_addr,
    output ctrl_pkg::ledger_req_t o_req,
    output logic [7:0]            o_led,
    output logic                  o_en_input,
    output logic                  o_addr_ready,
    output matrix_pkg::addr_t     o_base_addr,
    output logic                  o_start_calc,
    output ctrl_pkg::calc_cmd_t   o_calc_cmd,
    output logic                  o_logic_error
);
    import matrix_pkg::*;
    import ctrl_pkg::*;

    state_t     state_q;
    state_t     state_d;
    state_t     retry_q;
    logic [2:0] btn_s1;
    logic [2:0] btn_s2;
    logic [2:0] btn_d;
    logic [2:0] btn_rise;
    logic       confirm;
    logic       retry;
    logic       menu;
    op_t        op_q;
    op_t        sw_op;
    logic       op_ok;
    logic       stage_q;
    logic       chk_q;
    shape_t     dim_q;
    shape_t     op1_shape;
    shape_t     op2_shape;
    shape_t     res_shape;
    addr_t      op1_addr;
    addr_t      op2_addr;
    addr_t      dim_size;
    addr_t      id_addr;
    logic       id_ok;

    // ==================================================
    // buttons: 2-flop sync, then registered rising edge
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_s1   <= '0;
            btn_s2   <= '0;
            btn_d    <= '0;
            btn_rise <= '0;
        end else begin
            btn_s1   <= i_btn;
            btn_s2   <= btn_s1;
            btn_d    <= btn_s2;
            btn_rise <= btn_s2 & ~btn_d;
        end
    end

    assign confirm = btn_rise[0];
    assign retry   = btn_rise[1];
    assign menu    = btn_rise[2];

    assign sw_op = op_t'(i_sw[7:5]);

    always_comb begin
        case (sw_op)
            op_transpose, op_add, op_matmul: op_ok = 1'b1;
            default:                         op_ok = 1'b0;
        endcase
    end

    // predicted result shape
    always_comb begin
        case (op_q)
            op_transpose: res_shape = '{m: op1_shape.n, n: op1_shape.m};
            op_matmul:    res_shape = '{m: op1_shape.m, n: op2_shape.n};
            default:      res_shape = op1_shape;
        endcase
    end

    // ledger key follows the state
    always_comb begin
        o_req.commit = 1'b0;
        o_req.key    = dim_q;
        case (state_q)
            store: begin
                o_req.key    = i_dims;
                o_req.commit = i_dims_valid;
            end
            execute, wait_done: begin
                o_req.key    = res_shape;
                o_req.commit = (state_q == wait_done) && i_calc_done;
            end
            default: ;
        endcase
    end

    // copy id picks one half of the slot's pair
    assign dim_size = addr_t'(dim_q.m) * addr_t'(dim_q.n);
    assign id_addr  = i_hit_start + dim_size * addr_t'(i_id - 2'd1);
    assign id_ok    = (i_id != 2'd0) && (i_id <= i_hit_count);

    // ==================================================
    // next state
    // ==================================================
    always_comb begin
        state_d = state_q;
        if (menu) begin
            state_d = idle;
        end else begin
            case (state_q)
                idle: begin
                    if (confirm && i_sw[1:0] == MENU_STORE) begin
                        state_d = store;
                    end else if (confirm && i_sw[1:0] == MENU_CALC) begin
                        state_d = sel_op;
                    end
                end
                store: begin
                    if (i_timeout) begin
                        state_d = error;
                    end else if (i_rx_done) begin
                        state_d = decision;
                    end
                end
                sel_op: begin
                    if (confirm) begin
                        state_d = op_ok ? get_dim : error;
                    end
                end
                get_dim: begin
                    if (i_timeout) begin
                        state_d = error;
                    end else if (chk_q && i_hit) begin
                        state_d = get_id;
                    end
                end
                get_id: begin
                    if (i_timeout) begin
                        state_d = error;
                    end else if (i_id_valid && id_ok) begin
                        state_d = (stage_q || op_q == op_transpose) ? execute : get_dim;
                    end
                end
                execute:   state_d = wait_done;
                wait_done: begin
                    if (i_calc_done) begin
                        state_d = decision;
                    end
                end
                decision: begin
                    if (confirm) begin
                        state_d = idle;
                    end else if (retry) begin
                        state_d = retry_q;
                    end
                end
                error: begin
                    if (confirm) begin
                        state_d = idle;
                    end
                end
                default: state_d = idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= idle;
            retry_q       <= idle;
            op_q          <= op_transpose;
            stage_q       <= 1'b0;
            chk_q         <= 1'b0;
            o_addr_ready  <= 1'b0;
            o_start_calc  <= 1'b0;
            o_logic_error <= 1'b0;
        end else begin
            state_q      <= state_d;
            o_addr_ready <= (state_q == store) && i_dims_valid;
            o_start_calc <= (state_q == execute);
            // lookup of the new dims settles one cycle after the strobe
            chk_q        <= (state_q == get_dim) && i_dims_valid;
            case (state_q)
                idle: begin
                    o_logic_error <= 1'b0;
                    if (state_d != idle) begin
                        retry_q <= state_d;
                    end
                end
                sel_op: begin
                    if (confirm) begin
                        op_q    <= sw_op;
                        stage_q <= 1'b0;
                    end
                end
                get_dim: begin
                    if (i_dims_valid) begin
                        o_logic_error <= 1'b0;
                    end else if (chk_q && !i_hit) begin
                        o_logic_error <= 1'b1;
                    end
                end
                get_id: begin
                    if (i_id_valid) begin
                        o_logic_error <= !id_ok;
                        stage_q       <= stage_q | id_ok;
                    end
                end
                default: ;
            endcase
        end
    end

    // operand and command payload
    always_ff @(posedge clk) begin
        if (state_q == store && i_dims_valid) begin
            o_base_addr <= i_target_addr;
        end
        if (state_q == sel_op && confirm) begin
            op2_addr <= '0;
        end
        if (state_q == get_dim && i_dims_valid) begin
            dim_q <= i_dims;
        end
        if (state_q == get_id && i_id_valid && id_ok) begin
            if (!stage_q) begin
                op1_addr  <= id_addr;
                op1_shape <= dim_q;
            end else begin
                op2_addr  <= id_addr;
                op2_shape <= dim_q;
            end
        end
        if (state_q == execute) begin
            o_calc_cmd.op       <= op_q;
            o_calc_cmd.op1_addr <= op1_addr;
            o_calc_cmd.op2_addr <= op2_addr;
            o_calc_cmd.res_addr <= i_target_addr;
        end
    end

    always_comb begin
        case (state_q)
            idle:                    o_led = LED_IDLE;
            store:                   o_led = LED_STORE;
            sel_op, get_dim, get_id: o_led = LED_CALC;
            execute, wait_done:      o_led = LED_EXEC;
            decision:                o_led = LED_DECISION;
            default:                 o_led = LED_ERROR;
        endcase
    end

    assign o_en_input = (state_q == store) || (state_q == get_dim) || (state_q == get_id);

    // a command only leaves execute with a supported operation
    a_start_from_execute: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(o_start_calc) |-> ($past(state_q) == execute) &&
            (o_calc_cmd.op inside {op_transpose, op_add, op_matmul}));

endmodule

// File: verilog/matrix_ctrl_top.sv
module matrix_ctrl_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          i_sw,
    input  logic [2:0]          i_btn,
    input  matrix_pkg::shape_t  i_dims,
    input  logic                i_dims_valid,
    input  logic [1:0]          i_id,
    input  logic                i_id_valid,
    input  logic                i_rx_done,
    input  logic                i_timeout,
    input  logic                i_calc_done,
    output logic [7:0]          o_led,
    output logic                o_en_input,
    output logic                o_addr_ready,
    output matrix_pkg::addr_t   o_base_addr,
    output logic                o_start_calc,
    output ctrl_pkg::calc_cmd_t o_calc_cmd,
    output logic                o_logic_error,
    output logic [3:0]          o_type_count
);
    import matrix_pkg::*;
    import ctrl_pkg::*;

    ledger_req_t                 req;
    logic [NUM_SLOTS-1:0]        slot_load;
    logic [NUM_SLOTS-1:0]        slot_match;
    logic [NUM_SLOTS-1:0]        slot_bank;
    addr_t [NUM_SLOTS-1:0]       slot_start;
    copy_cnt_t [NUM_SLOTS-1:0]   slot_count;
    logic                        toggle_en;
    logic                        hit;
    logic                        hit_bank;
    addr_t                       hit_start;
    copy_cnt_t                   hit_count;
    addr_t                       free_ptr;
    addr_t                       target_addr;

    matrix_ctrl_fsm i_fsm (
        .clk, .rst_n, .i_sw, .i_btn, .i_dims, .i_dims_valid, .i_id, .i_id_valid,
        .i_rx_done, .i_timeout, .i_calc_done,
        .i_hit         (hit),
        .i_hit_start   (hit_start),
        .i_hit_count   (hit_count),
        .i_target_addr (target_addr),
        .o_req         (req),
        .o_led, .o_en_input, .o_addr_ready, .o_base_addr, .o_start_calc,
        .o_calc_cmd, .o_logic_error
    );

    ledger_writer i_writer (
        .clk, .rst_n,
        .i_req         (req),
        .i_hit         (hit),
        .i_hit_bank    (hit_bank),
        .i_hit_start   (hit_start),
        .o_load        (slot_load),
        .o_toggle_en   (toggle_en),
        .o_free_ptr    (free_ptr),
        .o_target_addr (target_addr),
        .o_type_count
    );

    // ==================================================
    // ledger slots
    // ==================================================
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
        shape_slot i_slot (
            .clk, .rst_n,
            .i_req    (req),
            .i_load   (slot_load[g]),
            .i_toggle (toggle_en & slot_match[g]),
            .i_start  (free_ptr),
            .o_match  (slot_match[g]),
            .o_start  (slot_start[g]),
            .o_bank   (slot_bank[g]),
            .o_count  (slot_count[g])
        );
    end

    ledger_match i_match (
        .clk,
        .i_match     (slot_match),
        .i_start     (slot_start),
        .i_bank      (slot_bank),
        .i_count     (slot_count),
        .o_hit       (hit),
        .o_hit_start (hit_start),
        .o_hit_bank  (hit_bank),
        .o_hit_count (hit_count)
    );

endmodule

// File: dv/matrix_ctrl_tb.sv
module matrix_ctrl_tb;
    import matrix_pkg::*;
    import ctrl_pkg::*;

    localparam int WAIT_LIMIT = 40;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_sw;
    logic [2:0]  i_btn;
    shape_t      i_dims;
    logic        i_dims_valid;
    logic [1:0]  i_id;
    logic        i_id_valid;
    logic        i_rx_done;
    logic        i_timeout;
    logic        i_calc_done;
    logic [7:0]  o_led;
    logic        o_en_input;
    logic        o_addr_ready;
    addr_t       o_base_addr;
    logic        o_start_calc;
    calc_cmd_t   o_calc_cmd;
    logic        o_logic_error;
    logic [3:0]  o_type_count;

    // ledger model
    shape_t      m_shape [NUM_SLOTS];
    addr_t       m_start [NUM_SLOTS];
    logic        m_bank  [NUM_SLOTS];
    copy_cnt_t   m_count [NUM_SLOTS];
    int          m_types;
    addr_t       m_free;

    // responses still owed by the DUT
    addr_t       exp_base_q [$];
    int          exp_due_q [$];
    calc_cmd_t   exp_cmd_q [$];

    logic [31:0] lfsr;
    int          cycle = 0;
    shape_t      hist [12];
    shape_t      sa;
    shape_t      sb;
    dim_t        dm;
    dim_t        dn;
    int          k;

    matrix_ctrl_top i_matrix_ctrl_top (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ==================================================
    // reference model
    // ==================================================
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic dim_t random_dim();
        logic [1:0] r;
        r[0] = lfsr_bit();
        r[1] = lfsr_bit();
        return dim_t'(r) + 8'd1;
    endfunction

    function automatic shape_t make_shape(dim_t m, dim_t n);
        shape_t s;
        s.m = m;
        s.n = n;
        return s;
    endfunction

    function automatic addr_t shape_size(shape_t s);
        return addr_t'(s.m) * addr_t'(s.n);
    endfunction

    function automatic int find_slot(shape_t s);
        for (int i = 0; i < m_types; i++) begin
            if (m_shape[i] == s) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic addr_t target_addr(shape_t s);
        int i;
        i = find_slot(s);
        if (i < 0) begin
            return m_free;
        end else if (m_bank[i]) begin
            return m_start[i] + shape_size(s);
        end else begin
            return m_start[i];
        end
    endfunction

    function automatic void ledger_commit(shape_t s);
        int i;
        i = find_slot(s);
        if (i >= 0) begin
            m_bank[i] = ~m_bank[i];
            if (m_count[i] < copy_cnt_t'(MAX_COPIES)) begin
                m_count[i] = m_count[i] + 2'd1;
            end
        end else if (m_types < NUM_SLOTS) begin
            m_shape[m_types] = s;
            m_start[m_types] = m_free;
            m_bank[m_types]  = 1'b1;
            m_count[m_types] = 2'd1;
            m_free  = m_free + shape_size(s) + shape_size(s);
            m_types = m_types + 1;
        end
    endfunction

    function automatic addr_t operand_addr(shape_t s, logic [1:0] id);
        int i;
        i = find_slot(s);
        return m_start[i] + shape_size(s) * addr_t'(id - 2'd1);
    endfunction

    function automatic shape_t result_shape(op_t op, shape_t s1, shape_t s2);
        case (op)
            op_transpose: return make_shape(s1.n, s1.m);
            op_matmul:    return make_shape(s1.m, s2.n);
            default:      return s1;
        endcase
    endfunction

    function automatic calc_cmd_t expected_cmd(op_t op, shape_t s1, logic [1:0] id1,
                                               shape_t s2, logic [1:0] id2);
        calc_cmd_t c;
        c.op       = op;
        c.op1_addr = operand_addr(s1, id1);
        c.op2_addr = (op == op_transpose) ? addr_t'(0) : operand_addr(s2, id2);
        c.res_addr = target_addr(result_shape(op, s1, s2));
        return c;
    endfunction

    // ==================================================
    // checks
    // ==================================================
    task automatic fail_run(string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error at time %0t: %s expected %h, got %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_cmd(calc_cmd_t exp, calc_cmd_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error at time %0t: o_calc_cmd expected %h, got %h",
                               $time, exp, act));
        end
    endtask

    task automatic check_led(logic [7:0] exp);
        if (o_led !== exp) begin
            fail_run($sformatf("Error at time %0t: o_led expected %b, got %b",
                               $time, exp, o_led));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("Error at time %0t: %s expected %b, got %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_count(logic [3:0] exp, logic [3:0] act);
        if (act !== exp) begin
            fail_run($sformatf("Error at time %0t: o_type_count expected %0d, got %0d",
                               $time, exp, act));
        end
    endtask

    // compare every strobe response against the queued expectation
    always @(negedge clk) begin
        if (rst_n && o_addr_ready) begin
            if (exp_base_q.size() == 0) begin
                fail_run("o_addr_ready was high with no store strobe pending");
            end else if (exp_due_q[0] != cycle) begin
                fail_run("o_addr_ready did not follow its store strobe by one cycle");
            end else begin
                void'(exp_due_q.pop_front());
                check_addr("o_base_addr", exp_base_q.pop_front(), o_base_addr);
            end
        end
        if (rst_n && o_start_calc) begin
            if (exp_cmd_q.size() == 0) begin
                fail_run("o_start_calc was high with no command expected");
            end else begin
                check_cmd(exp_cmd_q.pop_front(), o_calc_cmd);
            end
        end
    end

    // ==================================================
    // stimulus
    // ==================================================
    task automatic press(int b);
        i_btn[b] = 1'b1;
        repeat (4) @(negedge clk);
        i_btn[b] = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (exp_base_q.size() != 0 || exp_cmd_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_run("the DUT did not answer a strobe in time");
            end
        end
    endtask

    task automatic store_dims(shape_t s);
        i_dims       = s;
        i_dims_valid = 1'b1;
        exp_base_q.push_back(target_addr(s));
        exp_due_q.push_back(cycle + 1);
        ledger_commit(s);
        @(negedge clk);
        i_dims_valid = 1'b0;
        wait_responses();
        check_count(4'(m_types), o_type_count);
    endtask

    task automatic give_dims(shape_t s, logic exp_err);
        i_dims       = s;
        i_dims_valid = 1'b1;
        @(negedge clk);
        i_dims_valid = 1'b0;
        // lookup result lands one cycle later
        @(negedge clk);
        check_flag("o_logic_error", exp_err, o_logic_error);
    endtask

    task automatic give_id(logic [1:0] id, logic exp_err);
        i_id       = id;
        i_id_valid = 1'b1;
        @(negedge clk);
        i_id_valid = 1'b0;
        check_flag("o_logic_error", exp_err, o_logic_error);
    endtask

    task automatic enter_store();
        i_sw = {6'd0, MENU_STORE};
        press(0);
        check_led(LED_STORE);
        check_flag("o_en_input", 1'b1, o_en_input);
    endtask

    task automatic end_store();
        i_rx_done = 1'b1;
        @(negedge clk);
        i_rx_done = 1'b0;
        check_led(LED_DECISION);
        check_count(4'(m_types), o_type_count);
    endtask

    task automatic enter_calc(logic [2:0] code);
        i_sw = {code, 3'b000, MENU_CALC};
        press(0);
        check_led(LED_CALC);
        press(0);
    endtask

    task automatic run_calc(op_t op, shape_t s1, logic [1:0] id1, shape_t s2, logic [1:0] id2);
        calc_cmd_t cmd;
        enter_calc(op);
        check_led(LED_CALC);
        give_dims(s1, 1'b0);
        give_id(id1, 1'b0);
        if (op != op_transpose) begin
            give_dims(s2, 1'b0);
            give_id(id2, 1'b0);
        end
        cmd = expected_cmd(op, s1, id1, s2, id2);
        exp_cmd_q.push_back(cmd);
        wait_responses();
        check_led(LED_EXEC);
        i_calc_done = 1'b1;
        ledger_commit(result_shape(op, s1, s2));
        @(negedge clk);
        i_calc_done = 1'b0;
        check_led(LED_DECISION);
    endtask

    // store the result shape again to see where the ledger put it
    task automatic store_result(shape_t s);
        enter_store();
        store_dims(s);
        end_store();
        press(0);
        check_led(LED_IDLE);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_sw         = '0;
        i_btn        = '0;
        i_dims       = '0;
        i_dims_valid = 1'b0;
        i_id         = '0;
        i_id_valid   = 1'b0;
        i_rx_done    = 1'b0;
        i_timeout    = 1'b0;
        i_calc_done  = 1'b0;
        lfsr         = 32'h27ed288a;
        m_types      = 0;
        m_free       = '0;
        for (k = 0; k < NUM_SLOTS; k++) begin
            m_shape[k] = '0;
            m_start[k] = '0;
            m_bank[k]  = 1'b0;
            m_count[k] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        check_flag("o_en_input", 1'b0, o_en_input);
        check_flag("o_addr_ready", 1'b0, o_addr_ready);
        check_flag("o_start_calc", 1'b0, o_start_calc);
        check_flag("o_logic_error", 1'b0, o_logic_error);
        check_led(LED_IDLE);
        check_count(4'd0, o_type_count);

        // random shapes, every third one a repeat
        enter_store();
        for (k = 0; k < 12; k++) begin
            if (k % 3 == 2) begin
                hist[k] = hist[k-2];
            end else begin
                dm      = random_dim();
                dn      = random_dim();
                hist[k] = make_shape(dm, dn);
            end
            store_dims(hist[k]);
        end
        store_dims(hist[0]);
        end_store();
        press(0);
        check_led(LED_IDLE);

        // ==================================================
        // calculations
        // ==================================================
        sa = m_shape[0];
        sb = (m_types > 1) ? m_shape[1] : m_shape[0];
        run_calc(op_transpose, sa, 2'd1, sa, 2'd1);
        press(0);
        check_led(LED_IDLE);
        store_result(result_shape(op_transpose, sa, sa));
        run_calc(op_add, sa, m_count[0], sa, 2'd1);
        press(0);
        check_led(LED_IDLE);
        store_result(sa);
        run_calc(op_matmul, sa, 2'd1, sb, m_count[find_slot(sb)]);
        press(1);
        check_led(LED_CALC);
        press(2);
        check_led(LED_IDLE);
        store_result(result_shape(op_matmul, sa, sb));

        // fill the ledger, then one shape too many
        enter_store();
        k = 1;
        while (m_types < NUM_SLOTS) begin
            store_dims(make_shape(8'd9, dim_t'(k)));
            k++;
        end
        store_dims(make_shape(8'd9, 8'd40));
        store_dims(sa);
        end_store();
        press(1);
        check_led(LED_STORE);
        press(2);
        check_led(LED_IDLE);

        // logic errors, then timeout in get_id
        enter_calc(op_add);
        check_led(LED_CALC);
        give_dims(make_shape(8'd200, 8'd201), 1'b1);
        give_dims(sa, 1'b0);
        give_id(2'd0, 1'b1);
        give_id(m_count[0] + 2'd1, 1'b1);
        give_id(2'd1, 1'b0);
        give_dims(sa, 1'b0);
        i_timeout = 1'b1;
        @(negedge clk);
        i_timeout = 1'b0;
        check_led(LED_ERROR);
        press(2);
        check_led(LED_IDLE);

        // unsupported operation code
        enter_calc(3'd5);
        check_led(LED_ERROR);
        press(0);
        check_led(LED_IDLE);

        // menu from get_dim, store and decision
        enter_calc(op_matmul);
        check_led(LED_CALC);
        press(2);
        check_led(LED_IDLE);
        enter_store();
        press(2);
        check_led(LED_IDLE);
        enter_store();
        end_store();
        press(2);
        check_led(LED_IDLE);

        if (exp_base_q.size() != 0 || exp_cmd_q.size() != 0) begin
            fail_run("expected responses were still pending at the end");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: all.f
verilog/matrix_pkg.sv
verilog/ctrl_pkg.sv
verilog/shape_slot.sv
verilog/ledger_writer.sv
verilog/ledger_match.sv
verilog/matrix_ctrl_fsm.sv
verilog/matrix_ctrl_top.sv
dv/matrix_ctrl_tb.sv

// File: Makefile
SIM  := obj_dir/Vmatrix_ctrl_tb
SRCS := $(shell cat all.f)

.PHONY: run clean

run: $(SIM)
	-$(SIM) | tee sim.log
	grep -q "Test passed" sim.log

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module matrix_ctrl_tb -o Vmatrix_ctrl_tb

clean:
	rm -rf obj_dir sim.log
